// ==== common/spi_pkg.sv ====
package spi_pkg;

    // apb side widths
    typedef logic [3:0]  apb_addr_t;  // byte address inside the register block
    typedef logic [31:0] apb_data_t;  // apb data word

    // sclk half period is div+1 clk cycles
    typedef logic [7:0]  div_t;

    // miso passes two sync flops, so a half period of 3 clk is the floor
    localparam div_t DIV_MIN = 8'd2;
    localparam div_t DIV_RST = 8'd2;  // ctrl value out of reset

    // register map
    localparam apb_addr_t ADDR_CTRL   = 4'h0;  // rw, sclk divider
    localparam apb_addr_t ADDR_TXDATA = 4'h4;  // wo, write kicks off a transfer
    localparam apb_addr_t ADDR_RXDATA = 4'h8;  // ro, last received word
    localparam apb_addr_t ADDR_STATUS = 4'hC;  // ro, busy and done

    // status bit positions
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_DONE = 1;  // sticky, cleared by rxdata read

    // shift engine states
    typedef enum logic [1:0] {
        IDLE,   // cs_n high, waiting for start
        LEAD,   // cs_n low, msb on mosi, first half period running
        SHIFT,  // sample on rise, shift on fall
        TRAIL   // cs_n back high, done pulse
    } shift_state_t;

endpackage

// ==== logic/cell_sync.sv ====
module cell_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic in_p,   // async input, miso from the pad
    output logic out_p   // clk domain copy
);

    logic [SYNC_STAGES-1:0] chain;  // chain[0] may go metastable

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chain <= '0;
        end else begin
            chain <= {chain[SYNC_STAGES-2:0], in_p};  // shift towards the msb
        end
    end

    assign out_p = chain[SYNC_STAGES-1];  // last stage only

    // a single flop gives no settling time at all
    a_min_stages: assert property (@(posedge clk) SYNC_STAGES >= 2)
        else $error("cell_sync needs at least two stages");

endmodule

// ==== logic/sclk_gen.sv ====
module sclk_gen
    import spi_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic run,    // high while the shifter is in a transfer
    input  div_t div,    // half period minus one
    output logic sclk,
    output logic rise,   // sclk goes high at the end of this cycle
    output logic fall    // sclk goes low at the end of this cycle
);

    div_t timer;  // clk cycles spent in the current half period
    logic tc;     // terminal count

    assign tc = run && (timer == div);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer <= '0;
            sclk  <= 1'b0;  // mode 0 idles low
        end else if (!run) begin
            // parked so the next transfer opens with a full half period
            timer <= '0;
            sclk  <= 1'b0;
        end else if (tc) begin
            timer <= '0;
            sclk  <= ~sclk;
        end else begin
            timer <= timer + 8'd1;
        end
    end

    assign rise = tc && !sclk;  // low half ends
    assign fall = tc && sclk;   // high half ends

    a_one_edge: assert property (@(posedge clk) disable iff (rst) !(rise && fall))
        else $error("sclk_gen strobes rise and fall together");

endmodule

// ==== shifter/spi_shifter.sv ====
module spi_shifter
    import spi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,       // one cycle, from the txdata write
    input  logic [DATA_W-1:0] tx_word,
    input  logic              miso_s,      // already synchronized
    input  logic              rise,
    input  logic              fall,
    output logic              run,         // enables sclk_gen
    output logic              cs_n,
    output logic              mosi,
    output logic              busy,
    output logic              done_pulse,
    output logic [DATA_W-1:0] rx_word      // valid with done_pulse
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    typedef logic [DATA_W-1:0] word_t;

    shift_state_t     state;
    word_t            tx_sr;    // transmit shift reg, msb drives mosi
    word_t            rx_sr;    // receive shift reg, fills from the lsb
    logic [CNT_W-1:0] bit_cnt;  // bits still to go, counts down from DATA_W
    logic             active;   // lead or shift

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            cs_n    <= 1'b1;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE, TRAIL: begin
                    // back to back start is allowed straight out of trail
                    if (start) begin
                        state   <= LEAD;
                        cs_n    <= 1'b0;
                        bit_cnt <= CNT_W'(DATA_W);
                    end else begin
                        state <= IDLE;
                    end
                end
                LEAD: begin
                    state <= SHIFT;  // sclk_gen already counting
                end
                SHIFT: begin
                    if (fall) begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == CNT_W'(1)) begin
                            // last falling edge closes the frame
                            state <= TRAIL;
                            cs_n  <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // tx reg loads on start and moves one bit per fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_sr <= '0;
        end else if (start) begin
            tx_sr <= tx_word;  // msb shows up with cs_n low
        end else if (state == SHIFT && fall) begin
            tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};  // zero fill, mosi low after the word
        end
    end

    always_ff @(posedge clk) begin
        if (state == SHIFT && rise) begin
            rx_sr <= {rx_sr[DATA_W-2:0], miso_s};  // first bit ends at the msb
        end
    end

    assign active     = (state == LEAD) || (state == SHIFT);
    assign run        = active;
    assign busy       = active;
    assign done_pulse = (state == TRAIL);
    assign mosi       = tx_sr[DATA_W-1];
    assign rx_word    = rx_sr;

    // apb_regs has to refuse txdata writes during a transfer
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("spi_shifter got start while busy");

    a_cs_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !cs_n)
        else $error("spi_shifter busy with cs_n high");

endmodule

// ==== logic/apb_regs.sv ====
module apb_regs
    import spi_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  apb_addr_t         paddr,
    input  apb_data_t         pwdata,
    output apb_data_t         prdata,
    output logic              pready,
    output logic              pslverr,
    output div_t              div,         // to sclk_gen
    output logic              start,       // to the shifter
    output logic [DATA_W-1:0] tx_word,
    input  logic              busy,
    input  logic              done_pulse,
    input  logic [DATA_W-1:0] rx_word,
    output logic              done         // sticky done bit
);

    logic              access;   // second apb phase, transfer completes here
    logic              err;      // access would be refused
    logic              wr_ok;    // accepted write
    logic              rd_ok;    // accepted read
    div_t              div_q;
    logic [DATA_W-1:0] rx_q;
    logic              done_q;

    assign access = psel && penable;
    assign pready = 1'b1;  // no wait states

    always_comb begin
        case (paddr)
            ADDR_CTRL:   err = pwrite && (div_t'(pwdata) < DIV_MIN);
            ADDR_TXDATA: err = pwrite && busy;  // no queueing behind a transfer
            ADDR_RXDATA: err = pwrite;          // read only
            ADDR_STATUS: err = pwrite;          // read only
            default:     err = 1'b1;            // hole in the map
        endcase
    end

    assign pslverr = access && err;
    assign wr_ok   = access && pwrite && !err;
    assign rd_ok   = access && !pwrite && !err;

    assign start   = wr_ok && (paddr == ADDR_TXDATA);
    assign tx_word = pwdata[DATA_W-1:0];  // sampled by the shifter with start

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q <= DIV_RST;
        end else if (wr_ok && paddr == ADDR_CTRL) begin
            div_q <= div_t'(pwdata);
        end
    end

    // set beats clear when both hit in one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (done_pulse) begin
            done_q <= 1'b1;
        end else if (rd_ok && paddr == ADDR_RXDATA) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done_pulse) begin
            rx_q <= rx_word;  // capture, shifter reg is reused next frame
        end
    end

    always_comb begin
        prdata = '0;  // zero outside a good read
        if (rd_ok) begin
            case (paddr)
                ADDR_CTRL: begin
                    prdata[7:0] = div_q;
                end
                ADDR_RXDATA: begin
                    prdata[DATA_W-1:0] = rx_q;
                end
                ADDR_STATUS: begin
                    prdata[STATUS_BUSY] = busy;
                    prdata[STATUS_DONE] = done_q;
                end
                default: begin
                    prdata = '0;  // txdata reads back zero
                end
            endcase
        end
    end

    assign div  = div_q;
    assign done = done_q;

    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
        else $error("apb penable without psel");

    // the shifter must pick up every accepted start
    a_start_taken: assert property (@(posedge clk) disable iff (rst) start |=> busy)
        else $error("txdata write accepted but no transfer began");

endmodule

// ==== logic/spi_master.sv ====
module spi_master
    import spi_pkg::*;
#(
    parameter int DATA_W      = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      sclk,
    output logic      mosi,
    output logic      cs_n,
    input  logic      miso,
    output logic      done
);

    div_t              div;         // ctrl to divider
    logic              start;
    logic [DATA_W-1:0] tx_word;
    logic [DATA_W-1:0] rx_word;
    logic              busy;
    logic              done_pulse;
    logic              run;
    logic              rise;
    logic              fall;
    logic              miso_s;      // miso in the clk domain

    apb_regs #(
        .DATA_W(DATA_W)
    ) apb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .div        (div),
        .start      (start),
        .tx_word    (tx_word),
        .busy       (busy),
        .done_pulse (done_pulse),
        .rx_word    (rx_word),
        .done       (done)
    );

    sclk_gen sclk_gen_i (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .div  (div),
        .sclk (sclk),
        .rise (rise),
        .fall (fall)
    );

    cell_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) miso_sync_i (
        .clk   (clk),
        .rst   (rst),
        .in_p  (miso),
        .out_p (miso_s)
    );

    spi_shifter #(
        .DATA_W(DATA_W)
    ) spi_shifter_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .tx_word    (tx_word),
        .miso_s     (miso_s),
        .rise       (rise),
        .fall       (fall),
        .run        (run),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .busy       (busy),
        .done_pulse (done_pulse),
        .rx_word    (rx_word)
    );

endmodule

// ==== tests/spi_slave_model.sv ====
module spi_slave_model #(
    parameter int DATA_W = 8
) (
    input  logic              sclk,
    input  logic              cs_n,
    input  logic              mosi,
    output logic              miso,
    input  logic [DATA_W-1:0] reply,     // word to send in the next frame
    output logic [DATA_W-1:0] captured,  // mosi word of the last frame
    output int unsigned       frames     // completed frames
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [DATA_W-1:0] tx_sr;  // reply bits still to go, msb on miso
    logic [DATA_W-1:0] rx_sr;  // mosi bits, first one ends at the msb

    initial begin
        miso     = 1'b0;
        captured = '0;
        frames   = 0;
        tx_sr    = '0;
        rx_sr    = '0;
        forever begin
            @(negedge cs_n);
            tx_sr = reply;
            miso  = tx_sr[DATA_W-1];  // msb set up before the first rise
            while (!cs_n) begin
                @(sclk or cs_n);
                if (!cs_n && sclk) begin
                    rx_sr = {rx_sr[DATA_W-2:0], mosi};  // mode 0 sample on rise
                end else if (!cs_n && !sclk) begin
                    tx_sr = {tx_sr[DATA_W-2:0], 1'b0};
                    miso  = tx_sr[DATA_W-1];  // next bit after the fall
                end
            end
            captured = rx_sr;  // cs_n back high, frame closed
            frames++;
        end
    end

endmodule

// ==== tests/tb_spi_master.sv ====
module tb_spi_master
    import spi_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W     = 8;
    localparam int APB_LIMIT  = 16;    // cycles allowed for pready
    localparam int DONE_LIMIT = 5000;  // cycles allowed for one frame

    typedef logic [DATA_W-1:0] word_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        sclk;
    logic        mosi;
    logic        cs_n;
    logic        miso;
    logic        done;
    word_t       slave_reply;
    word_t       slave_word;
    int unsigned slave_frames;

    logic [15:0] lfsr_state = 16'd68;
    int          errors = 0;
    int          checks = 0;
    int          test_no = 0;
    int          failed_tests = 0;
    int          errors_at_start;
    string       test_name;
    div_t        exp_div;  // model of ctrl
    word_t       exp_rx;   // model of rxdata
    logic        cs_prev;
    logic        sclk_prev;
    int          run_len;   // clk cycles at the current sclk level
    int          hp_min;
    int          hp_max;
    int          rise_cnt;

    always #20 clk = ~clk;  // 40 ns period

    spi_master #(
        .DATA_W      (DATA_W),
        .SYNC_STAGES (2)
    ) spi_master_i (.*);

    spi_slave_model #(
        .DATA_W (DATA_W)
    ) spi_slave_model_i (
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso),
        .reply    (slave_reply),
        .captured (slave_word),
        .frames   (slave_frames)
    );

    // half period and rising edge count of the frame in flight
    always @(posedge clk) begin
        if (rst) begin
            cs_prev   = 1'b1;
            sclk_prev = 1'b0;
        end else begin
            if (!cs_n && cs_prev) begin
                run_len  = 1;  // frame opens, sclk low
                hp_min   = 1 << 20;
                hp_max   = 0;
                rise_cnt = 0;
            end else if (!cs_n && sclk == sclk_prev) begin
                run_len++;
            end else if (!cs_prev) begin
                // sclk toggled, or cs_n rose with the last fall
                hp_min   = (run_len < hp_min) ? run_len : hp_min;
                hp_max   = (run_len > hp_max) ? run_len : hp_max;
                rise_cnt = rise_cnt + ((sclk && !cs_n) ? 1 : 0);
                run_len  = 1;
            end
            cs_prev   = cs_n;
            sclk_prev = sclk;
        end
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = galois_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1;  // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;  // access phase
        @(posedge clk);
        while (!pready && waited < APB_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!pready) begin
            stop_on_timeout("apb access never saw pready");
        end else begin
            rdata   = prdata;  // sampled at the edge closing the access
            err     = pslverr;
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused_rd;
        apb_access(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!done && waited < DONE_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!done) begin
            stop_on_timeout("done never rose after a txdata write");
        end
    endtask

    task automatic set_div(input div_t d);
        logic err;
        apb_write(ADDR_CTRL, apb_data_t'(d), err);
        check_bit("pslverr", err, 1'b0);
        exp_div = d;
    endtask

    // one frame, optionally poking the block while it is busy
    task automatic run_transfer(input word_t tx, input word_t reply, input logic probe_busy);
        apb_data_t   rd;
        logic        err;
        int unsigned frames_before;
        slave_reply   = reply;
        frames_before = slave_frames;
        apb_write(ADDR_TXDATA, apb_data_t'(tx), err);
        check_bit("pslverr", err, 1'b0);
        if (probe_busy) begin
            apb_read(ADDR_STATUS, rd, err);
            check_data("status", rd, 32'h1);  // busy, done still clear
            apb_write(ADDR_TXDATA, apb_data_t'(~tx), err);
            check_bit("pslverr", err, 1'b1);  // dropped, frame keeps the first word
        end
        wait_done();
        check_word("slave_word", slave_word, tx);
        check_data("slave_frames", apb_data_t'(slave_frames), apb_data_t'(frames_before + 1));
        apb_read(ADDR_STATUS, rd, err);
        check_data("status", rd, 32'h2);
        apb_read(ADDR_RXDATA, rd, err);
        check_word("rxdata", rd[DATA_W-1:0], reply);
        exp_rx = reply;
        apb_read(ADDR_STATUS, rd, err);
        check_data("status", rd, 32'h0);  // rxdata read clears done
        check_bit("done", done, 1'b0);
    endtask

    task automatic confirm_regs();
        apb_data_t rd;
        logic      err;
        apb_read(ADDR_CTRL, rd, err);
        check_data("ctrl", rd, apb_data_t'(exp_div));
        apb_read(ADDR_RXDATA, rd, err);
        check_word("rxdata", rd[DATA_W-1:0], exp_rx);
        apb_read(ADDR_STATUS, rd, err);
        check_data("status", rd, 32'h0);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        test_no++;
        if (errors == errors_at_start) begin
            $display("test %0d (%s): passed", test_no, test_name);
        end else begin
            failed_tests++;
            $display("test %0d (%s): failed, %0d errors", test_no, test_name,
                     errors - errors_at_start);
        end
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        apb_addr_t bad_addr;
        rst         <= 1'b1;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= '0;
        pwdata      <= '0;
        slave_reply = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset state");
        apb_read(ADDR_STATUS, rd, err);
        check_data("status", rd, 32'h0);
        apb_read(ADDR_CTRL, rd, err);
        check_data("ctrl", rd, 32'h2);
        check_bit("cs_n", cs_n, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_bit("mosi", mosi, 1'b0);
        check_bit("done", done, 1'b0);
        exp_div = 8'd2;
        end_test();

        begin_test("random full-duplex transfers");
        repeat (20) begin
            set_div(div_t'(32'd2 + take_bits(2)));  // 2 to 5
            run_transfer(word_t'(take_bits(DATA_W)), word_t'(take_bits(DATA_W)), 1'b0);
        end
        end_test();

        begin_test("sclk half period and edge count");
        for (int d = 2; d <= 5; d++) begin
            set_div(div_t'(d));
            run_transfer(word_t'(take_bits(DATA_W)), word_t'(take_bits(DATA_W)), 1'b0);
            check_data("half_period_min", apb_data_t'(hp_min), apb_data_t'(d + 1));
            check_data("half_period_max", apb_data_t'(hp_max), apb_data_t'(d + 1));
            check_data("sclk_rises", apb_data_t'(rise_cnt), apb_data_t'(DATA_W));
        end
        end_test();

        begin_test("txdata write while busy");
        run_transfer(word_t'(take_bits(DATA_W)), word_t'(take_bits(DATA_W)), 1'b1);
        end_test();

        begin_test("illegal accesses");
        apb_write(ADDR_CTRL, 32'h0, err);
        check_bit("pslverr", err, 1'b1);
        apb_write(ADDR_CTRL, 32'h1, err);
        check_bit("pslverr", err, 1'b1);
        confirm_regs();
        repeat (4) begin
            bad_addr = apb_addr_t'(take_bits(4));
            if (bad_addr[1:0] == 2'b00) begin
                bad_addr[0] = 1'b1;  // off the word grid, never mapped
            end
            apb_write(bad_addr, take_bits(32), err);
            check_bit("pslverr", err, 1'b1);
            apb_read(bad_addr, rd, err);
            check_bit("pslverr", err, 1'b1);
        end
        apb_write(ADDR_RXDATA, take_bits(32), err);
        check_bit("pslverr", err, 1'b1);
        apb_write(ADDR_STATUS, take_bits(32), err);
        check_bit("pslverr", err, 1'b1);
        confirm_regs();
        check_bit("cs_n", cs_n, 1'b1);  // nothing started a frame
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_no, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/spi_pkg.sv
logic/cell_sync.sv
logic/sclk_gen.sv
shifter/spi_shifter.sv
logic/apb_regs.sv
logic/spi_master.sv
tests/spi_slave_model.sv
tests/tb_spi_master.sv

// ==== run.sh ====
#!/bin/sh
# build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_spi_master \
    -Mdir obj_dir \
    -f build.f

./obj_dir/Vtb_spi_master | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
